//--- hdl/trace_pkg.sv
/*
 * Shared definitions for the commit trace collector
 *   - field types of a trace record (pc, instruction word, stamp)
 *   - exception cause type, MSB flags an interrupt
 *   - default port count and queue depth for the top level
 */

package trace_pkg;

  // ----------------------------------------
  // Record field types
  // ----------------------------------------

  // Program counter of a committed instruction
  typedef logic [63:0] pc_t;

  // Raw instruction word
  typedef logic [31:0] insn_t;

  // Exception cause, top bit set for interrupts
  typedef logic [63:0] cause_t;

  // Free-running cycle count at commit
  typedef logic [31:0] stamp_t;

  // ----------------------------------------
  // Default configuration
  // ----------------------------------------

  // Number of commit ports watched
  parameter int unsigned DefaultNrCommitPorts = 2;

  // Records held per port before overflow
  parameter int unsigned DefaultQueueDepth = 4;

endpackage

//--- hdl/trace_rec_if.sv
/*
 * Valid/ready link carrying one trace record
 *   - producer drives valid and the record fields
 *   - consumer drives ready
 *   - a record moves on a rising edge with valid and ready both high
 */

`timescale 1ns/1ps

interface trace_rec_if;
  import trace_pkg::*;

  logic   valid;
  logic   ready;
  pc_t    pc;
  insn_t  insn;
  stamp_t stamp;

  // Side that offers records
  modport producer (
    output valid,
    output pc,
    output insn,
    output stamp,
    input  ready
  );

  // Side that takes records
  modport consumer (
    input  valid,
    input  pc,
    input  insn,
    input  stamp,
    output ready
  );

endinterface

//--- hdl/commit_classifier.sv
/*
 * Commit classifier
 *   - registers every commit port and sorts it into retired,
 *     exception or interrupt
 *   - free-running cycle counter used as record stamp
 *   - offers retired records to the per-port queues
 *   - sticky overflow bit when a queue refuses a record
 */

`timescale 1ns/1ps

module commit_classifier #(
  parameter int unsigned NrCommitPorts = trace_pkg::DefaultNrCommitPorts
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic             [NrCommitPorts-1:0]  commit_ack_i,
  input  trace_pkg::pc_t   [NrCommitPorts-1:0]  commit_pc_i,
  input  trace_pkg::insn_t [NrCommitPorts-1:0]  commit_insn_i,
  input  logic             [NrCommitPorts-1:0]  commit_ex_valid_i,
  input  trace_pkg::cause_t [NrCommitPorts-1:0] commit_cause_i,
  output logic             [NrCommitPorts-1:0]  exception_o,
  output logic             [NrCommitPorts-1:0]  interrupt_o,
  output logic             [NrCommitPorts-1:0]  overflow_o,
  trace_rec_if.producer                         push_if [NrCommitPorts-1:0]
);
  import trace_pkg::*;

  localparam int unsigned CauseMsb = $bits(cause_t) - 1;

  logic   [NrCommitPorts-1:0] cause_msb;
  logic   [NrCommitPorts-1:0] push_ready;
  logic   [NrCommitPorts-1:0] retire_q;
  logic   [NrCommitPorts-1:0] exc_q;
  logic   [NrCommitPorts-1:0] irq_q;
  logic   [NrCommitPorts-1:0] overflow_q;
  stamp_t                     cycle_q;
  stamp_t                     stamp_q;
  pc_t    [NrCommitPorts-1:0] pc_q;
  insn_t  [NrCommitPorts-1:0] insn_q;

  // ----------------------------------------
  // Kind decode and control registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_q   <= '0;
      exc_q      <= '0;
      irq_q      <= '0;
      overflow_q <= '0;
      cycle_q    <= '0;
    end else begin
      retire_q   <= commit_ack_i & ~commit_ex_valid_i;
      exc_q      <= commit_ack_i & commit_ex_valid_i & ~cause_msb;
      irq_q      <= commit_ack_i & commit_ex_valid_i & cause_msb;
      // Record offered but queue full, it is lost
      overflow_q <= overflow_q | (retire_q & ~push_ready);
      cycle_q    <= cycle_q + stamp_t'(1);
    end
  end

  // Record payload, captured only for retirements
  always_ff @(posedge clk_i) begin
    if (|commit_ack_i) begin
      stamp_q <= cycle_q;
    end
    for (int p = 0; p < NrCommitPorts; p++) begin
      if (commit_ack_i[p] && !commit_ex_valid_i[p]) begin
        pc_q[p]   <= commit_pc_i[p];
        insn_q[p] <= commit_insn_i[p];
      end
    end
  end

  // ----------------------------------------
  // Per-port queue connection
  // ----------------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_port
    assign cause_msb[i]     = commit_cause_i[i][CauseMsb];
    assign push_if[i].valid = retire_q[i];
    assign push_if[i].pc    = pc_q[i];
    assign push_if[i].insn  = insn_q[i];
    assign push_if[i].stamp = stamp_q;
    assign push_ready[i]    = push_if[i].ready;
  end

  assign exception_o = exc_q;
  assign interrupt_o = irq_q;
  assign overflow_o  = overflow_q;

endmodule

//--- hdl/pc_queue.sv
/*
 * Per-port PC queue
 *   - circular buffer of trace records
 *   - read and write pointers with a fill count
 *   - ready low while full, oldest record always presented
 */

`timescale 1ns/1ps

module pc_queue #(
  parameter int unsigned QueueDepth = trace_pkg::DefaultQueueDepth
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  trace_rec_if.consumer push_if,
  trace_rec_if.producer pop_if
);
  import trace_pkg::*;

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  pc_t    pc_mem    [QueueDepth];
  insn_t  insn_mem  [QueueDepth];
  stamp_t stamp_mem [QueueDepth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign push_if.ready = (count_q != CntW'(QueueDepth));
  assign pop_if.valid  = (count_q != '0);

  assign push = push_if.valid & push_if.ready;
  assign pop  = pop_if.valid & pop_if.ready;

  // Head of the queue
  assign pop_if.pc    = pc_mem[rd_ptr_q];
  assign pop_if.insn  = insn_mem[rd_ptr_q];
  assign pop_if.stamp = stamp_mem[rd_ptr_q];

  // ----------------------------------------
  // Pointers and fill level
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_q == PtrW'(QueueDepth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + PtrW'(1);
        end
      end
      if (pop) begin
        if (rd_ptr_q == PtrW'(QueueDepth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + PtrW'(1);
        end
      end
      // Simultaneous push and pop keeps the level
      case ({push, pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      pc_mem[wr_ptr_q]    <= push_if.pc;
      insn_mem[wr_ptr_q]  <= push_if.insn;
      stamp_mem[wr_ptr_q] <= push_if.stamp;
    end
  end

endmodule

//--- hdl/trace_arbiter.sv
/*
 * Trace arbiter
 *   - round-robin choice among non-empty PC queues
 *   - four-phase req/ack handshake on the trace output
 *   - selected queue popped when ack is seen high
 */

`timescale 1ns/1ps

module trace_arbiter #(
  parameter  int unsigned NrCommitPorts = trace_pkg::DefaultNrCommitPorts,
  localparam int unsigned PortW         = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              trace_ack_i,
  output logic              trace_req_o,
  output trace_pkg::pc_t    trace_pc_o,
  output trace_pkg::insn_t  trace_insn_o,
  output trace_pkg::stamp_t trace_stamp_o,
  output logic [PortW-1:0]  trace_port_o,
  trace_rec_if.consumer     pop_if [NrCommitPorts-1:0]
);
  import trace_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StWaitAckHi,
    StWaitAckLo
  } state_e;

  state_e state_q;

  // Port of the last grant, also the port on the output
  logic   [PortW-1:0]         sel_q;
  logic   [PortW-1:0]         pick;
  logic                       found;
  logic   [NrCommitPorts-1:0] head_valid;
  pc_t    [NrCommitPorts-1:0] head_pc;
  insn_t  [NrCommitPorts-1:0] head_insn;
  stamp_t [NrCommitPorts-1:0] head_stamp;
  pc_t                        pc_q;
  insn_t                      insn_q;
  stamp_t                     stamp_q;

  // ----------------------------------------
  // Queue heads and pop strobes
  // ----------------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_head
    assign head_valid[i]   = pop_if[i].valid;
    assign head_pc[i]      = pop_if[i].pc;
    assign head_insn[i]    = pop_if[i].insn;
    assign head_stamp[i]   = pop_if[i].stamp;
    assign pop_if[i].ready = (state_q == StWaitAckHi) && trace_ack_i &&
                             (sel_q == PortW'(i));
  end

  // Search starts one past the last grant and wraps
  always_comb begin
    logic [PortW-1:0] cand;
    pick  = sel_q;
    found = 1'b0;
    for (int k = 1; k <= NrCommitPorts; k++) begin
      cand = PortW'((int'(sel_q) + k) % NrCommitPorts);
      if (!found && head_valid[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Handshake FSM
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      // Port 0 wins first after reset
      sel_q   <= PortW'(NrCommitPorts - 1);
    end else begin
      case (state_q)
        StIdle: begin
          if (found) begin
            sel_q   <= pick;
            state_q <= StWaitAckHi;
          end
        end
        StWaitAckHi: begin
          if (trace_ack_i) begin
            state_q <= StWaitAckLo;
          end
        end
        StWaitAckLo: begin
          if (!trace_ack_i) begin
            state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Output record, frozen while req is up
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && found) begin
      pc_q    <= head_pc[pick];
      insn_q  <= head_insn[pick];
      stamp_q <= head_stamp[pick];
    end
  end

  assign trace_req_o   = (state_q == StWaitAckHi);
  assign trace_pc_o    = pc_q;
  assign trace_insn_o  = insn_q;
  assign trace_stamp_o = stamp_q;
  assign trace_port_o  = sel_q;

endmodule

//--- hdl/commit_tracer.sv
/*
 * Commit trace collector top level
 *   - commit classifier feeding one PC queue per port
 *   - round-robin trace arbiter draining the queues
 *   - four-phase req/ack trace output, per-port event flags
 */

`timescale 1ns/1ps

module commit_tracer #(
  parameter  int unsigned NrCommitPorts = trace_pkg::DefaultNrCommitPorts,
  parameter  int unsigned QueueDepth    = trace_pkg::DefaultQueueDepth,
  localparam int unsigned PortW         = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Commit ports
  input  logic              [NrCommitPorts-1:0] commit_ack_i,
  input  trace_pkg::pc_t    [NrCommitPorts-1:0] commit_pc_i,
  input  trace_pkg::insn_t  [NrCommitPorts-1:0] commit_insn_i,
  input  logic              [NrCommitPorts-1:0] commit_ex_valid_i,
  input  trace_pkg::cause_t [NrCommitPorts-1:0] commit_cause_i,
  // Trace output
  input  logic                                  trace_ack_i,
  output logic                                  trace_req_o,
  output trace_pkg::pc_t                        trace_pc_o,
  output trace_pkg::insn_t                      trace_insn_o,
  output trace_pkg::stamp_t                     trace_stamp_o,
  output logic              [PortW-1:0]         trace_port_o,
  // Event flags
  output logic              [NrCommitPorts-1:0] exception_o,
  output logic              [NrCommitPorts-1:0] interrupt_o,
  output logic              [NrCommitPorts-1:0] overflow_o
);

  trace_rec_if push_if [NrCommitPorts-1:0] ();
  trace_rec_if pop_if  [NrCommitPorts-1:0] ();

  commit_classifier #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_classifier (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_insn_i     ( commit_insn_i     ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_cause_i    ( commit_cause_i    ),
    .exception_o       ( exception_o       ),
    .interrupt_o       ( interrupt_o       ),
    .overflow_o        ( overflow_o        ),
    .push_if           ( push_if           )
  );

  // One queue per commit port
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_queue
    pc_queue #(
      .QueueDepth ( QueueDepth )
    ) i_pc_queue (
      .clk_i   ( clk_i      ),
      .rst_ni  ( rst_ni     ),
      .push_if ( push_if[i] ),
      .pop_if  ( pop_if[i]  )
    );
  end

  trace_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .trace_ack_i   ( trace_ack_i   ),
    .trace_req_o   ( trace_req_o   ),
    .trace_pc_o    ( trace_pc_o    ),
    .trace_insn_o  ( trace_insn_o  ),
    .trace_stamp_o ( trace_stamp_o ),
    .trace_port_o  ( trace_port_o  ),
    .pop_if        ( pop_if        )
  );

endmodule

//--- verif/commit_tracer_props.sv
/*
 * Concurrent checks on the four-phase trace output
 *   - record held while req waits for ack
 *   - req drops only after ack, rises only with ack low
 */

`timescale 1ns/1ps

module commit_tracer_props #(
  parameter  int unsigned NrCommitPorts = trace_pkg::DefaultNrCommitPorts,
  localparam int unsigned PortW         = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              trace_req_i,
  input logic              trace_ack_i,
  input trace_pkg::pc_t    trace_pc_i,
  input trace_pkg::insn_t  trace_insn_i,
  input trace_pkg::stamp_t trace_stamp_i,
  input logic [PortW-1:0]  trace_port_i
);

  // Record frozen until the receiver acknowledges
  a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trace_req_i && !trace_ack_i) |=>
      $stable({trace_pc_i, trace_insn_i, trace_stamp_i, trace_port_i}))
    else $error("Trace record changed while req waited for ack");

  a_req_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(trace_req_i) |-> $past(trace_ack_i))
    else $error("Trace req dropped before ack rose");

  // New request only after the previous ack is gone
  a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(trace_req_i) |-> !trace_ack_i)
    else $error("Trace req rose while ack was still high");

endmodule

bind commit_tracer commit_tracer_props #(
  .NrCommitPorts ( NrCommitPorts )
) i_props (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .trace_req_i   ( trace_req_o   ),
  .trace_ack_i   ( trace_ack_i   ),
  .trace_pc_i    ( trace_pc_o    ),
  .trace_insn_i  ( trace_insn_o  ),
  .trace_stamp_i ( trace_stamp_o ),
  .trace_port_i  ( trace_port_o  )
);

//--- verif/tb_commit_tracer.sv
/*
 * Directed testbench for the commit trace collector
 *   - clock, reset and cycle-count watchdog
 *   - reference model of stamps and per-port queues
 *   - four-phase responder and the directed tests
 */

`timescale 1ns/1ps

module tb_commit_tracer;
  import trace_pkg::*;

  localparam int unsigned NrPorts  = DefaultNrCommitPorts;
  localparam int unsigned Depth    = DefaultQueueDepth;
  localparam int unsigned PortW    = (NrPorts > 1) ? $clog2(NrPorts) : 1;
  localparam int unsigned FastAck  = 2;
  localparam int unsigned SlowAck  = 6;
  // Worst case for one record through the handshake
  localparam int unsigned HsCycles = 2 * SlowAck + 8;
  localparam int unsigned RunCycles = 60 + 2 * Depth * (3 + HsCycles) + 2 * Depth * HsCycles
                                      + (Depth + 3) + Depth * HsCycles;
  localparam int unsigned TimeoutCycles = 2 * RunCycles;

  typedef struct packed {
    pc_t    pc;
    insn_t  insn;
    stamp_t stamp;
  } rec_t;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic   [NrPorts-1:0] commit_ack_i;
  pc_t    [NrPorts-1:0] commit_pc_i;
  insn_t  [NrPorts-1:0] commit_insn_i;
  logic   [NrPorts-1:0] commit_ex_valid_i;
  cause_t [NrPorts-1:0] commit_cause_i;
  logic                 trace_ack_i;
  logic                 trace_req_o;
  pc_t                  trace_pc_o;
  insn_t                trace_insn_o;
  stamp_t               trace_stamp_o;
  logic   [PortW-1:0]   trace_port_o;
  logic   [NrPorts-1:0] exception_o;
  logic   [NrPorts-1:0] interrupt_o;
  logic   [NrPorts-1:0] overflow_o;

  // Reference model state
  rec_t                 exp_q [NrPorts][$];
  logic   [NrPorts-1:0] exp_ovf;
  stamp_t               cycle_cnt;
  int unsigned          run_cycles = 0;

  commit_tracer i_dut (.*);

  always #4 clk_i = ~clk_i;

  // Free-running count held at zero in reset
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + stamp_t'(1);
    end
  end

  always @(posedge clk_i) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= TimeoutCycles) begin
      report_failure("Timeout: the trace output stopped making progress");
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else report_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Model queue drops the record once full
  task automatic expect_record(input int port, input rec_t rec);
    if (exp_q[port].size() < Depth) begin
      exp_q[port].push_back(rec);
    end else begin
      exp_ovf[port] = 1'b1;
    end
  endtask

  task automatic retire_burst(input logic [NrPorts-1:0] mask, input int count,
                              input int max_gap);
    rec_t rec;
    int   gap;
    for (int i = 0; i < count; i++) begin
      @(posedge clk_i);
      // DUT samples the count one edge later
      rec.stamp = cycle_cnt + stamp_t'(1);
      commit_ack_i <= mask;
      for (int p = 0; p < NrPorts; p++) begin
        if (mask[p]) begin
          rec.pc   = {$urandom, $urandom};
          rec.insn = $urandom;
          commit_pc_i[p]   <= rec.pc;
          commit_insn_i[p] <= rec.insn;
          expect_record(p, rec);
        end
      end
      gap = $urandom_range(max_gap, 0);
      if (gap > 0) begin
        @(posedge clk_i);
        commit_ack_i <= '0;
        repeat (gap - 1) @(posedge clk_i);
      end
    end
    @(posedge clk_i);
    commit_ack_i <= '0;
  endtask

  // Receiver side of the four-phase handshake
  task automatic receive_record(input int max_delay, output int port, output bit both_busy);
    rec_t rec;
    int   busy;
    @(negedge clk_i);
    while (!trace_req_o) @(negedge clk_i);
    port = int'(trace_port_o);
    busy = 0;
    for (int p = 0; p < NrPorts; p++) begin
      busy += (exp_q[p].size() > 0);
    end
    both_busy = (busy > 1);
    assert (exp_q[port].size() > 0)
      else report_failure($sformatf("A record came out of port %0d with none expected", port));
    rec = exp_q[port].pop_front();
    check_eq("trace_pc_o", trace_pc_o, rec.pc);
    check_eq("trace_insn_o", trace_insn_o, rec.insn);
    check_eq("trace_stamp_o", trace_stamp_o, rec.stamp);
    repeat ($urandom_range(max_delay, 0)) @(posedge clk_i);
    @(posedge clk_i);
    trace_ack_i <= 1'b1;
    @(negedge clk_i);
    while (trace_req_o) @(negedge clk_i);
    repeat ($urandom_range(max_delay, 0)) @(posedge clk_i);
    @(posedge clk_i);
    trace_ack_i <= 1'b0;
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic reset_values();
    @(negedge clk_i);
    check_eq("trace_req_o", trace_req_o, '0);
    check_eq("exception_o", exception_o, '0);
    check_eq("interrupt_o", interrupt_o, '0);
    check_eq("overflow_o", overflow_o, '0);
  endtask

  task automatic single_port_order();
    int port;
    bit both_busy;
    for (int round = 0; round < 2; round++) begin
      retire_burst(NrPorts'(1), Depth, 2);
      for (int i = 0; i < Depth; i++) begin
        receive_record(FastAck, port, both_busy);
      end
    end
  endtask

  task automatic dual_port_round_robin();
    int port;
    int last;
    bit both_busy;
    retire_burst('1, Depth, 0);
    last = -1;
    for (int i = 0; i < 2 * Depth; i++) begin
      receive_record(SlowAck, port, both_busy);
      if (both_busy && last >= 0) begin
        assert (port != last)
          else report_failure($sformatf("Port %0d was granted twice in a row", port));
      end
      last = port;
    end
  endtask

  task automatic event_pulses();
    logic [NrPorts-1:0] irq;
    logic [NrPorts-1:0] exc;
    for (int k = 0; k < 2; k++) begin
      for (int p = 0; p < NrPorts; p++) begin
        irq[p] = ((p + k) % 2) != 0;
      end
      exc = ~irq;
      @(posedge clk_i);
      commit_ack_i      <= '1;
      commit_ex_valid_i <= '1;
      for (int p = 0; p < NrPorts; p++) begin
        commit_cause_i[p] <= {irq[p], 63'($urandom)};
      end
      @(negedge clk_i);
      check_eq("exception_o", exception_o, '0);
      check_eq("interrupt_o", interrupt_o, '0);
      @(posedge clk_i);
      commit_ack_i      <= '0;
      commit_ex_valid_i <= '0;
      @(negedge clk_i);
      check_eq("exception_o", exception_o, exc);
      check_eq("interrupt_o", interrupt_o, irq);
      @(negedge clk_i);
      check_eq("exception_o", exception_o, '0);
      check_eq("interrupt_o", interrupt_o, '0);
    end
    // Events leave nothing in the queues
    repeat (4) begin
      @(negedge clk_i);
      check_eq("trace_req_o", trace_req_o, '0);
    end
  endtask

  task automatic overflow_drop();
    int port;
    bit both_busy;
    retire_burst(NrPorts'(1), Depth + 3, 0);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_eq("overflow_o[0]", overflow_o[0], 1'b1);
    check_eq("overflow_o", overflow_o, exp_ovf);
    for (int i = 0; i < Depth; i++) begin
      receive_record(FastAck, port, both_busy);
    end
    repeat (6) begin
      @(negedge clk_i);
      check_eq("trace_req_o", trace_req_o, '0);
    end
    check_eq("overflow_o", overflow_o, exp_ovf);
  endtask

  task automatic queues_empty();
    for (int p = 0; p < NrPorts; p++) begin
      assert (exp_q[p].size() == 0)
        else report_failure($sformatf("Port %0d still has %0d records outstanding",
                                      p, exp_q[p].size()));
    end
  endtask

  initial begin
    int unsigned seed;
    seed              = $urandom(32'hd969_6475);
    rst_ni            = 1'b0;
    commit_ack_i      = '0;
    commit_pc_i       = '0;
    commit_insn_i     = '0;
    commit_ex_valid_i = '0;
    commit_cause_i    = '0;
    trace_ack_i       = 1'b0;
    exp_ovf           = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_values();
    single_port_order();
    dual_port_round_robin();
    event_pulses();
    overflow_drop();
    queues_empty();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- vlog.f
hdl/trace_pkg.sv
hdl/trace_rec_if.sv
hdl/commit_classifier.sv
hdl/pc_queue.sv
hdl/trace_arbiter.sv
hdl/commit_tracer.sv
verif/commit_tracer_props.sv
verif/tb_commit_tracer.sv
